// ==== sim.f ====
+incdir+include
rtl/ddr_bridge_pkg.sv
rtl/ddr_beat_queue.sv
rtl/ddr_line_splitter.sv
rtl/ddr_app_issuer.sv
rtl/ddr_line_assembler.sv
rtl/ddr_bridge_top.sv
verification/app_memory_model.sv
verification/tb_ddr_bridge.sv

// ==== verification/tb_ddr_bridge.sv ====
/*
 * Testbench for the CPU line to DDR2 app-interface bridge. Issues line
 * reads and writes against a controller model and checks the beat split,
 * back-pressure, completion timing and read-back with assertions.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module tb_ddr_bridge;

    import ddr_bridge_pkg::*;

    localparam logic [31:0] SEED   = 32'h38f6_0c54;
    localparam int NUM_LINES       = 8;
    localparam int NUM_RANDOM      = 30;
    localparam int NUM_REQUESTS    = 2 * NUM_LINES + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES  = 40 * NUM_REQUESTS + 200;
    localparam int REQ_BITS        = `DDR_APP_ADDR_BITS + 3;

    logic                          ui_clk;
    logic                          rst;
    logic                          ram_en;
    logic                          ram_write;
    logic [`DDR_CPU_ADDR_BITS-1:0] ram_addr;
    line_t                         data_to_ram;
    logic                          ram_rdy;
    line_t                         data_from_ram;
    logic                          line_valid;
    app_addr_t                     app_addr;
    app_cmd_t                      app_cmd;
    logic                          app_en;
    beat_t                         app_wdf_data;
    logic                          app_wdf_wren;
    logic                          app_wdf_end;
    logic                          app_rdy;
    logic                          app_wdf_rdy;
    beat_t                         app_rd_data;
    logic                          app_rd_data_valid;
    logic                          init_calib_complete;

    // Bookkeeping
    integer seed;
    string  test_name = "none";
    int     error_count = 0;
    int     check_count = 0;
    int     tests_run = 0;
    int     test_base_errors = 0;
    int     cycle_count = 0;
    int     cmd_stall_count = 0;
    int     data_stall_count = 0;

    logic [`DDR_CPU_ADDR_BITS-1:0] line_addr [NUM_LINES];
    line_t                         ref_mem [NUM_LINES];
    logic [REQ_BITS-1:0]           exp_req [$];
    beat_t                         exp_wdata [$];
    line_t                         exp_rline;

    // Outstanding request as seen from the CPU side
    logic busy = 1'b0;
    logic busy_write = 1'b0;
    int   cmd_cnt = 0;
    int   data_cnt = 0;
    int   cmd_next;
    int   data_next;

    ddr_bridge_top ddr_bridge_top_inst (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_en              (ram_en),
        .ram_write           (ram_write),
        .ram_addr            (ram_addr),
        .data_to_ram         (data_to_ram),
        .ram_rdy             (ram_rdy),
        .data_from_ram       (data_from_ram),
        .line_valid          (line_valid),
        .app_addr            (app_addr),
        .app_cmd             (app_cmd),
        .app_en              (app_en),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .app_wdf_end         (app_wdf_end),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .init_calib_complete (init_calib_complete)
    );

    app_memory_model #(.SEED(SEED)) memory_model (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .app_addr            (app_addr),
        .app_cmd             (app_cmd),
        .app_en              (app_en),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .init_calib_complete (init_calib_complete)
    );

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk;
    end

    task automatic report_mismatch(input string what, input logic [255:0] expected,
                                   input logic [255:0] actual);
        error_count++;
        $display("[FAIL] %s %s: expected %h actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("[ERROR] %s: %s", test_name, msg);
    endtask

    function automatic line_t random_line();
        line_t v;
        for (int k = 0; k < 8; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Protocol assertions
    // ------------------------------------------------------------------------
    assert property (@(posedge ui_clk)
        !rst |=> (!ram_rdy && !app_en && !app_wdf_wren && !line_valid))
        else report_problem("outputs not idle after reset");

    assert property (@(posedge ui_clk) disable iff (!rst)
        !init_calib_complete |-> !ram_rdy)
        else report_problem("ram_rdy high before calibration completed");

    assert property (@(posedge ui_clk) disable iff (!rst)
        busy && !line_valid |-> !ram_rdy)
        else report_problem("ram_rdy high while a request is in progress");

    assert property (@(posedge ui_clk) disable iff (!rst)
        init_calib_complete && (!busy || (!busy_write && line_valid)) |-> ram_rdy)
        else report_problem("ram_rdy did not return after completion");

    assert property (@(posedge ui_clk) disable iff (!rst)
        line_valid |-> busy && !busy_write)
        else report_problem("line_valid pulse without a pending read");

    assert property (@(posedge ui_clk) disable iff (!rst)
        app_en && !app_rdy |=> app_en && $stable(app_addr) && $stable(app_cmd))
        else report_problem("command dropped or changed under back-pressure");

    assert property (@(posedge ui_clk) disable iff (!rst)
        app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data))
        else report_problem("write beat dropped or changed under back-pressure");

    assert property (@(posedge ui_clk) disable iff (!rst)
        app_wdf_end == app_wdf_wren)
        else report_problem("app_wdf_end does not follow app_wdf_wren");

    // ------------------------------------------------------------------------
    // Transfer monitor
    // ------------------------------------------------------------------------
    always @(posedge ui_clk) begin
        if (!rst) begin
            busy       <= 1'b0;
            busy_write <= 1'b0;
            cmd_cnt    <= 0;
            data_cnt   <= 0;
        end else begin
            if (app_en && !app_rdy) begin
                cmd_stall_count++;
            end
            if (app_wdf_wren && !app_wdf_rdy) begin
                data_stall_count++;
            end
            if (app_en && app_rdy) begin
                check_count++;
                if (exp_req.size() == 0) begin
                    report_problem("command issued with no command expected");
                end else begin
                    assert ({app_cmd, app_addr} == exp_req[0])
                        else report_mismatch("command", exp_req[0], {app_cmd, app_addr});
                    void'(exp_req.pop_front());
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                check_count++;
                if (exp_wdata.size() == 0) begin
                    report_problem("write beat sent with no beat expected");
                end else begin
                    assert (app_wdf_data == exp_wdata[0])
                        else report_mismatch("write beat", exp_wdata[0], app_wdf_data);
                    void'(exp_wdata.pop_front());
                end
            end
            if (line_valid && busy && !busy_write) begin
                check_count++;
                assert (data_from_ram == exp_rline)
                    else report_mismatch("read line", exp_rline, data_from_ram);
            end

            cmd_next  = cmd_cnt + ((app_en && app_rdy) ? 1 : 0);
            data_next = data_cnt + ((app_wdf_wren && app_wdf_rdy) ? 1 : 0);
            cmd_cnt  <= cmd_next;
            data_cnt <= data_next;
            if (busy_write && cmd_next == 2 && data_next == 2) begin
                busy <= 1'b0;
            end
            if (!busy_write && line_valid) begin
                busy <= 1'b0;
            end
            if (ram_en && ram_rdy) begin
                busy       <= 1'b1;
                busy_write <= ram_write;
                cmd_cnt    <= 0;
                data_cnt   <= 0;
            end
        end
    end

    // One request from ram_rdy to completion
    task automatic run_request(input logic write, input int idx, input line_t data);
        logic [21:0] line_bits;
        line_bits = line_addr[idx][24:3];
        @(negedge ui_clk);
        while (!ram_rdy) begin
            @(negedge ui_clk);
        end
        exp_req.push_back({write ? 3'd0 : 3'd1, line_bits, 5'd0});
        exp_req.push_back({write ? 3'd0 : 3'd1, line_bits, 5'd16});
        if (write) begin
            exp_wdata.push_back(data[`DDR_BEAT_BITS-1:0]);
            exp_wdata.push_back(data[`DDR_LINE_BITS-1:`DDR_BEAT_BITS]);
            ref_mem[idx] = data;
        end else begin
            exp_rline = ref_mem[idx];
        end
        @(posedge ui_clk);
        ram_en      <= 1'b1;
        ram_write   <= write;
        ram_addr    <= line_addr[idx];
        data_to_ram <= data;
        @(posedge ui_clk);
        ram_en <= 1'b0;
        @(negedge ui_clk);
        while (busy) begin
            @(negedge ui_clk);
        end
    endtask

    task automatic finish_test();
        if (exp_req.size() != 0 || exp_wdata.size() != 0) begin
            report_problem("expected transfers never reached the controller");
        end
        tests_run++;
        $display("Test %s done with %0d errors", test_name, error_count - test_base_errors);
        test_base_errors = error_count;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic write;
        int   idx;
        seed        = SEED;
        rst         = 1'b0;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_addr    = '0;
        data_to_ram = '0;
        // Random bits outside 24..3 must not affect the beat address
        for (int i = 0; i < NUM_LINES; i++) begin
            line_addr[i]       = $random(seed);
            line_addr[i][24:3] = 22'h2a_5000 + 22'(i * 97);
        end
        repeat (5) @(posedge ui_clk);
        rst <= 1'b1;

        test_name = "reset_calib";
        @(negedge ui_clk);
        while (!ram_rdy) begin
            @(negedge ui_clk);
        end
        finish_test();

        test_name = "write_split";
        for (int i = 0; i < NUM_LINES; i++) begin
            run_request(1'b1, i, random_line());
        end
        finish_test();

        test_name = "read_back";
        for (int i = 0; i < NUM_LINES; i++) begin
            run_request(1'b0, i, random_line());
        end
        finish_test();

        test_name = "random_mix";
        repeat (NUM_RANDOM) begin
            write = $random(seed) & 1;
            idx   = $random(seed) & (NUM_LINES - 1);
            run_request(write, idx, random_line());
        end
        if (cmd_stall_count == 0) begin
            report_problem("command back-pressure never occurred");
        end
        if (data_stall_count == 0) begin
            report_problem("write-data back-pressure never occurred");
        end
        finish_test();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge ui_clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/app_memory_model.sv ====
/*
 * Behavioural stand-in for the DDR2 controller app interface. Random stalls
 * on app_rdy and app_wdf_rdy, a sparse beat store, in-order reads with a
 * fixed latency, and calibration done a few cycles after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module app_memory_model #(
    parameter logic [31:0] SEED = 32'h38f6_0c54
) (
    input  wire logic                 ui_clk,
    input  wire logic                 rst,
    input  ddr_bridge_pkg::app_addr_t app_addr,
    input  ddr_bridge_pkg::app_cmd_t  app_cmd,
    input  wire logic                 app_en,
    input  ddr_bridge_pkg::beat_t     app_wdf_data,
    input  wire logic                 app_wdf_wren,
    output logic                      app_rdy,
    output logic                      app_wdf_rdy,
    output ddr_bridge_pkg::beat_t     app_rd_data,
    output logic                      app_rd_data_valid,
    output logic                      init_calib_complete
);

    import ddr_bridge_pkg::*;

    localparam int CALIB_CYCLES = 10;
    localparam int READ_LATENCY = 3;

    integer    stall_seed = SEED;
    int        calib_cnt;
    beat_t     mem [app_addr_t];
    app_addr_t wr_addr_q [$];
    beat_t     wr_data_q [$];
    logic      [READ_LATENCY-2:0] rd_vld_pipe;
    beat_t     rd_data_pipe [READ_LATENCY-1];

    function automatic beat_t read_beat(input app_addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // Unwritten locations give a pattern built from the address
        return {4{{5'b0, addr} ^ 32'h6b1d_0e37}};
    endfunction

    initial begin
        app_rdy             = 1'b0;
        app_wdf_rdy         = 1'b0;
        app_rd_data         = '0;
        app_rd_data_valid   = 1'b0;
        init_calib_complete = 1'b0;
    end

    always @(posedge ui_clk) begin
        if (!rst) begin
            calib_cnt           <= 0;
            init_calib_complete <= 1'b0;
            app_rdy             <= 1'b0;
            app_wdf_rdy         <= 1'b0;
            rd_vld_pipe         <= '0;
            app_rd_data_valid   <= 1'b0;
        end else begin
            if (calib_cnt == CALIB_CYCLES - 1) begin
                init_calib_complete <= 1'b1;
            end else begin
                calib_cnt <= calib_cnt + 1;
            end

            // Roughly one stall in four on each ready
            app_rdy     <= init_calib_complete && (($random(stall_seed) & 3) != 0);
            app_wdf_rdy <= init_calib_complete && (($random(stall_seed) & 3) != 0);

            // Write commands and write beats pair up in order
            if (app_en && app_rdy && app_cmd == APP_CMD_WRITE) begin
                wr_addr_q.push_back(app_addr);
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wr_data_q.push_back(app_wdf_data);
            end
            while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
                mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();
            end

            // ----------------------------------------------------------------------
            // Read return pipeline
            // ----------------------------------------------------------------------
            rd_vld_pipe[0]  <= app_en && app_rdy && app_cmd == APP_CMD_READ;
            rd_data_pipe[0] <= read_beat(app_addr);
            for (int s = 1; s < READ_LATENCY - 1; s++) begin
                rd_vld_pipe[s]  <= rd_vld_pipe[s-1];
                rd_data_pipe[s] <= rd_data_pipe[s-1];
            end
            app_rd_data_valid <= rd_vld_pipe[READ_LATENCY-2];
            app_rd_data       <= rd_data_pipe[READ_LATENCY-2];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ddr_bridge_top.sv ====
/*
 * Bridge from a 256-bit CPU line port to a DDR2 controller app interface.
 * Splitter feeds a command queue and a write-data queue, the issuer drains
 * them into the controller, and the assembler rebuilds read lines.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module ddr_bridge_top (
    input  wire logic                          ui_clk,
    input  wire logic                          rst,
    // CPU side
    input  wire logic                          ram_en,
    input  wire logic                          ram_write,
    input  wire logic [`DDR_CPU_ADDR_BITS-1:0] ram_addr,
    input  ddr_bridge_pkg::line_t              data_to_ram,
    output logic                               ram_rdy,
    output ddr_bridge_pkg::line_t              data_from_ram,
    output logic                               line_valid,
    // Controller app interface
    output ddr_bridge_pkg::app_addr_t          app_addr,
    output ddr_bridge_pkg::app_cmd_t           app_cmd,
    output logic                               app_en,
    output ddr_bridge_pkg::beat_t              app_wdf_data,
    output logic                               app_wdf_wren,
    output logic                               app_wdf_end,
    input  wire logic                          app_rdy,
    input  wire logic                          app_wdf_rdy,
    input  ddr_bridge_pkg::beat_t              app_rd_data,
    input  wire logic                          app_rd_data_valid,
    input  wire logic                          init_calib_complete
);

    import ddr_bridge_pkg::*;

    logic     cmd_push;
    app_req_t cmd_data;
    logic     cmd_pop;
    app_req_t cmd_head;
    logic     cmd_empty;
    logic     wdata_push;
    beat_t    wdata_data;
    logic     wdata_pop;
    beat_t    wdata_head;
    logic     wdata_empty;
    logic     write_beat_done;

    // ------------------------------------------------------------------------
    // Producer
    // ------------------------------------------------------------------------
    ddr_line_splitter splitter (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_en              (ram_en),
        .ram_write           (ram_write),
        .ram_addr            (ram_addr),
        .data_to_ram         (data_to_ram),
        .init_calib_complete (init_calib_complete),
        .write_beat_done     (write_beat_done),
        .line_valid          (line_valid),
        .ram_rdy             (ram_rdy),
        .cmd_push            (cmd_push),
        .cmd_data            (cmd_data),
        .wdata_push          (wdata_push),
        .wdata_data          (wdata_data)
    );

    // At most two entries in flight per queue, so neither one fills
    ddr_beat_queue #(.payload_t(app_req_t)) cmd_queue (
        .ui_clk    (ui_clk),
        .rst       (rst),
        .push      (cmd_push),
        .push_data (cmd_data),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .full      (),
        .empty     (cmd_empty)
    );

    ddr_beat_queue #(.payload_t(beat_t)) wdata_queue (
        .ui_clk    (ui_clk),
        .rst       (rst),
        .push      (wdata_push),
        .push_data (wdata_data),
        .pop       (wdata_pop),
        .pop_data  (wdata_head),
        .full      (),
        .empty     (wdata_empty)
    );

    // ------------------------------------------------------------------------
    // Consumers
    // ------------------------------------------------------------------------
    ddr_app_issuer issuer (
        .ui_clk          (ui_clk),
        .rst             (rst),
        .cmd_head        (cmd_head),
        .cmd_empty       (cmd_empty),
        .cmd_pop         (cmd_pop),
        .wdata_head      (wdata_head),
        .wdata_empty     (wdata_empty),
        .wdata_pop       (wdata_pop),
        .app_rdy         (app_rdy),
        .app_wdf_rdy     (app_wdf_rdy),
        .app_addr        (app_addr),
        .app_cmd         (app_cmd),
        .app_en          (app_en),
        .app_wdf_data    (app_wdf_data),
        .app_wdf_wren    (app_wdf_wren),
        .app_wdf_end     (app_wdf_end),
        .write_beat_done (write_beat_done)
    );

    ddr_line_assembler assembler (
        .ui_clk            (ui_clk),
        .rst               (rst),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .data_from_ram     (data_from_ram),
        .line_valid        (line_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/ddr_line_assembler.sv ====
/*
 * Rebuilds a CPU line from two read beats returned by the controller.
 * The first valid beat fills the lower half, the second the upper half,
 * and line_valid pulses on the following cycle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module ddr_line_assembler (
    input  wire logic             ui_clk,
    input  wire logic             rst,
    input  ddr_bridge_pkg::beat_t app_rd_data,
    input  wire logic             app_rd_data_valid,
    output ddr_bridge_pkg::line_t data_from_ram,
    output logic                  line_valid
);

    // Set once the lower half holds its beat
    logic upper_half;

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            upper_half <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= app_rd_data_valid && upper_half;
            if (app_rd_data_valid) begin
                upper_half <= !upper_half;
            end
        end
    end

    // Line register
    always_ff @(posedge ui_clk) begin
        if (app_rd_data_valid) begin
            if (upper_half) begin
                data_from_ram[`DDR_LINE_BITS-1:`DDR_BEAT_BITS] <= app_rd_data;
            end else begin
                data_from_ram[`DDR_BEAT_BITS-1:0] <= app_rd_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ddr_app_issuer.sv ====
/*
 * Presents the command at the head of the command queue to the controller,
 * with its data beat for a write. Command and data may be accepted in
 * different cycles; the queue entries are popped once both have gone.
 */
`timescale 1ns/1ps
`default_nettype none

module ddr_app_issuer (
    input  wire logic                 ui_clk,
    input  wire logic                 rst,
    input  ddr_bridge_pkg::app_req_t  cmd_head,
    input  wire logic                 cmd_empty,
    output logic                      cmd_pop,
    input  ddr_bridge_pkg::beat_t     wdata_head,
    input  wire logic                 wdata_empty,
    output logic                      wdata_pop,
    input  wire logic                 app_rdy,
    input  wire logic                 app_wdf_rdy,
    output ddr_bridge_pkg::app_addr_t app_addr,
    output ddr_bridge_pkg::app_cmd_t  app_cmd,
    output logic                      app_en,
    output ddr_bridge_pkg::beat_t     app_wdf_data,
    output logic                      app_wdf_wren,
    output logic                      app_wdf_end,
    output logic                      write_beat_done
);

    import ddr_bridge_pkg::*;

    logic is_write;
    logic cmd_done;
    logic data_done;
    logic cmd_xfer;
    logic data_xfer;
    logic finish;

    assign is_write = (cmd_head.cmd == APP_CMD_WRITE);

    // Head entry stays put until popped, so values hold under back-pressure
    assign app_addr     = cmd_head.addr;
    assign app_cmd      = cmd_head.cmd;
    assign app_wdf_data = wdata_head;

    assign app_en       = !cmd_empty && !cmd_done;
    assign app_wdf_wren = !cmd_empty && is_write && !wdata_empty && !data_done;
    // Every write is a single beat
    assign app_wdf_end  = app_wdf_wren;

    assign cmd_xfer  = app_en && app_rdy;
    assign data_xfer = app_wdf_wren && app_wdf_rdy;

    // Command and data both transferred in this or an earlier cycle
    assign finish = !cmd_empty && (cmd_done || cmd_xfer) &&
                    (!is_write || data_done || data_xfer);

    assign cmd_pop         = finish;
    assign wdata_pop       = finish && is_write;
    assign write_beat_done = finish && is_write;

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            cmd_done  <= 1'b0;
            data_done <= 1'b0;
        end else if (finish) begin
            cmd_done  <= 1'b0;
            data_done <= 1'b0;
        end else begin
            cmd_done  <= cmd_done || cmd_xfer;
            data_done <= data_done || data_xfer;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ddr_line_splitter.sv ====
/*
 * Accepts one CPU line request at a time and turns it into two beat
 * commands, plus two write beats for a write. Holds ram_rdy low until the
 * controller has taken both write beats or the read line has come back.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module ddr_line_splitter (
    input  wire logic                          ui_clk,
    input  wire logic                          rst,
    input  wire logic                          ram_en,
    input  wire logic                          ram_write,
    input  wire logic [`DDR_CPU_ADDR_BITS-1:0] ram_addr,
    input  ddr_bridge_pkg::line_t              data_to_ram,
    input  wire logic                          init_calib_complete,
    input  wire logic                          write_beat_done,
    input  wire logic                          line_valid,
    output logic                               ram_rdy,
    output logic                               cmd_push,
    output ddr_bridge_pkg::app_req_t           cmd_data,
    output logic                               wdata_push,
    output ddr_bridge_pkg::beat_t              wdata_data
);

    import ddr_bridge_pkg::*;

    // Low five address bits select the half of the line
    localparam int OFS_BITS = 5;
    localparam logic [OFS_BITS-1:0] LOWER_OFS = 5'd0;
    localparam logic [OFS_BITS-1:0] UPPER_OFS = 5'd16;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,
        ST_SECOND,
        ST_WAIT
    } state_t;

    state_t state;
    logic   is_write;
    logic   [1:0] done_cnt;
    logic   accept;
    logic   [`DDR_APP_ADDR_BITS-OFS_BITS-1:0] base_addr;
    line_t  line_buf;

    // Read completion lets a new request in on the line_valid cycle
    assign ram_rdy = init_calib_complete &&
                     ((state == ST_IDLE) || (state == ST_WAIT && !is_write && line_valid));
    assign accept  = ram_en && ram_rdy;

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state    <= ST_IDLE;
            is_write <= 1'b0;
            done_cnt <= 2'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_FIRST;
                    end
                end
                ST_FIRST: begin
                    state <= ST_SECOND;
                end
                ST_SECOND: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (is_write) begin
                        // Second beat taken by the controller
                        if (write_beat_done && done_cnt == 2'd1) begin
                            state <= ST_IDLE;
                        end
                    end else if (line_valid) begin
                        state <= accept ? ST_FIRST : ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            if (accept) begin
                is_write <= ram_write;
                done_cnt <= 2'd0;
            end else if (write_beat_done) begin
                done_cnt <= done_cnt + 2'd1;
            end
        end
    end

    // Request payload with bits 24..3 as the line address
    always_ff @(posedge ui_clk) begin
        if (accept) begin
            base_addr <= ram_addr[24:3];
            line_buf  <= data_to_ram;
        end
    end

    // ------------------------------------------------------------------------
    // Queue pushes with the lower half first
    // ------------------------------------------------------------------------
    assign cmd_push      = (state == ST_FIRST) || (state == ST_SECOND);
    assign cmd_data.cmd  = is_write ? APP_CMD_WRITE : APP_CMD_READ;
    assign cmd_data.addr = {base_addr, (state == ST_SECOND) ? UPPER_OFS : LOWER_OFS};

    assign wdata_push = cmd_push && is_write;
    assign wdata_data = (state == ST_SECOND) ? line_buf[`DDR_LINE_BITS-1:`DDR_BEAT_BITS]
                                             : line_buf[`DDR_BEAT_BITS-1:0];

endmodule

`default_nettype wire

// ==== rtl/ddr_beat_queue.sv ====
/*
 * Small synchronous circular queue. The payload type is a parameter, so the
 * same block carries commands and write beats. Head data is visible on
 * pop_data the cycle after a push; push when full and pop when empty are ignored.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module ddr_beat_queue #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic ui_clk,
    input  wire logic rst,
    input  wire logic push,
    input  payload_t  push_data,
    input  wire logic pop,
    output payload_t  pop_data,
    output logic      full,
    output logic      empty
);

    localparam int DEPTH    = `DDR_QUEUE_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ui_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ddr_bridge_pkg.sv ====
/*
 * Types shared by the bridge modules: beats, lines, controller addresses,
 * the app command encoding and the command-queue entry.
 * Compile before any module of the bridge.
 */
`default_nettype none

`include "ddr_bridge_settings.svh"

package ddr_bridge_pkg;

    typedef logic [`DDR_BEAT_BITS-1:0]     beat_t;
    typedef logic [`DDR_LINE_BITS-1:0]     line_t;
    typedef logic [`DDR_APP_ADDR_BITS-1:0] app_addr_t;

    // Controller app_cmd encoding
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'b000,
        APP_CMD_READ  = 3'b001
    } app_cmd_t;

    // One entry of the command queue
    typedef struct packed {
        app_cmd_t  cmd;
        app_addr_t addr;
    } app_req_t;

endpackage

`default_nettype wire

// ==== include/ddr_bridge_settings.svh ====
/*
 * Width and depth settings for the CPU line to DDR2 app-interface bridge.
 * Include wherever a width or the queue depth is needed.
 */
`ifndef DDR_BRIDGE_SETTINGS_SVH
`define DDR_BRIDGE_SETTINGS_SVH

// One controller beat and one CPU cache line
`define DDR_BEAT_BITS      128
`define DDR_LINE_BITS      256

// Controller address and CPU word address
`define DDR_APP_ADDR_BITS  27
`define DDR_CPU_ADDR_BITS  30

// Entries in each command and write-data queue
`define DDR_QUEUE_DEPTH    4

`endif
